// File: Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = pito_core_tb
FLIST    = project.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// File: hw/pito_core.sv
`timescale 1ns/1ps

module pito_core #(
    parameter int NUM_HARTS   = 8,
    parameter int IMEM_ADDR_W = 13
) (
    input  logic                    clk,
    input  logic                    pito_io_rst_n,
    input  logic                    pito_io_program,
    input  pito_core_pkg::imem_wr_t imem_wr,
    output pito_core_pkg::retire_t  retire
);

    // ========================================
    // stage wires
    // ========================================
    // fetch -> decode
    logic                    fet_valid;
    pito_core_pkg::hart_id_t fet_hart;
    pito_core_pkg::pc_t      fet_pc;
    rv32_isa_pkg::instr_u    fet_instr;
    // decode <-> regfile, decode -> execute
    rv32_isa_pkg::reg_addr_t ra1;
    rv32_isa_pkg::reg_addr_t ra2;
    rv32_isa_pkg::data_t     rd1;
    rv32_isa_pkg::data_t     rd2;
    logic                    dec_valid;
    pito_core_pkg::dec_op_t  dec_op;
    // execute -> write
    logic                    ex_valid;
    pito_core_pkg::ex_res_t  ex_res;
    // write -> regfile / fetch
    logic                    wen;
    pito_core_pkg::hart_id_t w_hart;
    rv32_isa_pkg::reg_addr_t wa;
    rv32_isa_pkg::data_t     wd;
    logic                    pc_upd_en;
    pito_core_pkg::hart_id_t pc_upd_hart;
    pito_core_pkg::pc_t      pc_upd_val;

    pito_fetch #(.NUM_HARTS(NUM_HARTS), .IMEM_ADDR_W(IMEM_ADDR_W)) u_fetch (
        .clk(clk), .pito_io_rst_n(pito_io_rst_n), .pito_io_program(pito_io_program),
        .imem_wr(imem_wr), .pc_upd_en(pc_upd_en), .pc_upd_hart(pc_upd_hart),
        .pc_upd_val(pc_upd_val), .fet_valid(fet_valid), .fet_hart(fet_hart),
        .fet_pc(fet_pc), .fet_instr(fet_instr)
    );

    pito_decode u_decode (
        .clk(clk), .pito_io_rst_n(pito_io_rst_n), .fet_valid(fet_valid),
        .fet_hart(fet_hart), .fet_pc(fet_pc), .fet_instr(fet_instr),
        .ra1(ra1), .ra2(ra2), .dec_valid(dec_valid), .dec_op(dec_op)
    );

    // read side follows the fetch record hart
    pito_regfile #(.NUM_HARTS(NUM_HARTS)) u_regfile (
        .clk(clk), .rd_hart(fet_hart), .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .wen(wen), .w_hart(w_hart), .wa(wa), .wd(wd)
    );

    pito_execute u_execute (
        .clk(clk), .pito_io_rst_n(pito_io_rst_n), .dec_valid(dec_valid),
        .dec_op(dec_op), .rd1(rd1), .rd2(rd2), .ex_valid(ex_valid), .ex_res(ex_res)
    );

    pito_writeback u_writeback (
        .clk(clk), .pito_io_rst_n(pito_io_rst_n), .ex_valid(ex_valid), .ex_res(ex_res),
        .wen(wen), .w_hart(w_hart), .wa(wa), .wd(wd), .pc_upd_en(pc_upd_en),
        .pc_upd_hart(pc_upd_hart), .pc_upd_val(pc_upd_val), .retire(retire)
    );

endmodule

// File: hw/pito_core_pkg.sv
package pito_core_pkg;

    // ========================================
    // barrel scheduling
    // ========================================
    // up to 8 harts, index always carried at full width
    localparam int HART_ID_W       = 3;
    localparam int HART_BASE_SHIFT = 12;
    // word index width of the io write record
    localparam int IMEM_WR_ADDR_W  = 13;

    typedef logic [HART_ID_W-1:0] hart_id_t;
    typedef logic [31:0]          pc_t;

    // ========================================
    // stage records
    // ========================================
    // decode -> execute, operand values travel separately
    typedef struct packed {
        hart_id_t               hart;
        pc_t                    pc;
        rv32_isa_pkg::alu_op_t  alu_op;
        rv32_isa_pkg::br_kind_t br_kind;
        rv32_isa_pkg::reg_addr_t rd;
        logic                   rd_wen;
        logic                   use_imm;
        logic                   is_branch;
        logic                   is_jal;
        logic                   is_lui;
        rv32_isa_pkg::data_t    imm;
    } dec_op_t;

    // execute -> write
    typedef struct packed {
        hart_id_t                hart;
        pc_t                     pc;
        rv32_isa_pkg::reg_addr_t rd;
        logic                    rd_wen;
        rv32_isa_pkg::data_t     result;
        logic                    redirect;
        pc_t                     target;
    } ex_res_t;

    // io side instruction write strobe
    typedef struct packed {
        logic                      en;
        logic [IMEM_WR_ADDR_W-1:0] addr;
        rv32_isa_pkg::data_t       data;
    } imem_wr_t;

    // observable retirement
    typedef struct packed {
        logic                    valid;
        hart_id_t                hart;
        pc_t                     pc;
        logic                    rd_wen;
        rv32_isa_pkg::reg_addr_t rd;
        rv32_isa_pkg::data_t     rd_data;
    } retire_t;

endpackage

// File: hw/pito_decode.sv
`timescale 1ns/1ps

module pito_decode (
    input  logic                        clk,
    input  logic                        pito_io_rst_n,
    input  logic                        fet_valid,
    input  pito_core_pkg::hart_id_t     fet_hart,
    input  pito_core_pkg::pc_t          fet_pc,
    input  rv32_isa_pkg::instr_u        fet_instr,
    output rv32_isa_pkg::reg_addr_t     ra1,
    output rv32_isa_pkg::reg_addr_t     ra2,
    output logic                        dec_valid,
    output pito_core_pkg::dec_op_t      dec_op
);

    rv32_isa_pkg::r_view_t  r;
    pito_core_pkg::dec_op_t dec_c;
    logic                   legal;
    logic                   alt;

    assign r = fet_instr.r_view;

    // register file addresses go out straight from the word
    assign ra1 = r.rs1;
    assign ra2 = r.rs2;

    // ========================================
    // field classification
    // ========================================
    always_comb begin
        dec_c      = '0;
        dec_c.hart = fet_hart;
        dec_c.pc   = fet_pc;
        dec_c.rd   = r.rd;
        legal      = 1'b0;
        // funct7 bit 5 picks sub / sra, only for the shift form on OP_IMM
        alt        = r.funct7[5] && (r.opcode == rv32_isa_pkg::OPC_OP || r.funct3 == 3'b101);

        case (r.funct3)
            3'b000:  dec_c.alu_op = alt ? rv32_isa_pkg::ALU_SUB : rv32_isa_pkg::ALU_ADD;
            3'b001:  dec_c.alu_op = rv32_isa_pkg::ALU_SLL;
            3'b010:  dec_c.alu_op = rv32_isa_pkg::ALU_SLT;
            3'b011:  dec_c.alu_op = rv32_isa_pkg::ALU_SLTU;
            3'b100:  dec_c.alu_op = rv32_isa_pkg::ALU_XOR;
            3'b101:  dec_c.alu_op = alt ? rv32_isa_pkg::ALU_SRA : rv32_isa_pkg::ALU_SRL;
            3'b110:  dec_c.alu_op = rv32_isa_pkg::ALU_OR;
            default: dec_c.alu_op = rv32_isa_pkg::ALU_AND;
        endcase

        case (r.funct3)
            3'b000:  dec_c.br_kind = rv32_isa_pkg::BR_EQ;
            3'b001:  dec_c.br_kind = rv32_isa_pkg::BR_NE;
            3'b100:  dec_c.br_kind = rv32_isa_pkg::BR_LT;
            3'b101:  dec_c.br_kind = rv32_isa_pkg::BR_GE;
            3'b110:  dec_c.br_kind = rv32_isa_pkg::BR_LTU;
            default: dec_c.br_kind = rv32_isa_pkg::BR_GEU;
        endcase

        case (r.opcode)
            rv32_isa_pkg::OPC_OP: begin
                // only sub and sra use the alternate funct7
                legal = (r.funct7 == 7'h00) ||
                        (r.funct7 == 7'h20 && (r.funct3 == 3'b000 || r.funct3 == 3'b101));
            end
            rv32_isa_pkg::OPC_OP_IMM: begin
                dec_c.use_imm = 1'b1;
                dec_c.imm     = {{20{fet_instr.i_view.imm[11]}}, fet_instr.i_view.imm};
                // shift immediates carry a funct7 field
                legal = (r.funct3 == 3'b001) ? (r.funct7 == 7'h00) :
                        (r.funct3 == 3'b101) ? (r.funct7 == 7'h00 || r.funct7 == 7'h20) : 1'b1;
            end
            rv32_isa_pkg::OPC_LUI: begin
                dec_c.is_lui = 1'b1;
                dec_c.imm    = {r.funct7, r.rs2, r.rs1, r.funct3, 12'b0};
                legal        = 1'b1;
            end
            rv32_isa_pkg::OPC_BRANCH: begin
                // funct3 010 and 011 are unused
                dec_c.is_branch = (r.funct3[2:1] != 2'b01);
                dec_c.imm = {{19{r.funct7[6]}}, r.funct7[6], r.rd[0], r.funct7[5:0],
                             r.rd[4:1], 1'b0};
            end
            rv32_isa_pkg::OPC_JAL: begin
                dec_c.is_jal = 1'b1;
                dec_c.imm = {{11{r.funct7[6]}}, r.funct7[6], r.rs1, r.funct3, r.rs2[0],
                             r.funct7[5:0], r.rs2[4:1], 1'b0};
                legal     = 1'b1;
            end
            default: begin
                // anything else retires as a no-op
                legal = 1'b0;
            end
        endcase

        // x0 is never written
        dec_c.rd_wen = legal && (r.rd != 5'd0);
    end

    // ========================================
    // decode register
    // ========================================
    always_ff @(posedge clk) begin
        dec_op <= dec_c;
        if (!pito_io_rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fet_valid;
        end
    end

endmodule

// File: hw/pito_execute.sv
`timescale 1ns/1ps

module pito_execute (
    input  logic                   clk,
    input  logic                   pito_io_rst_n,
    input  logic                   dec_valid,
    input  pito_core_pkg::dec_op_t dec_op,
    input  rv32_isa_pkg::data_t    rd1,
    input  rv32_isa_pkg::data_t    rd2,
    output logic                   ex_valid,
    output pito_core_pkg::ex_res_t ex_res
);

    rv32_isa_pkg::data_t rs1_q;
    rv32_isa_pkg::data_t rs2_q;
    rv32_isa_pkg::data_t op_b;
    rv32_isa_pkg::data_t alu;
    logic [4:0]          shamt;
    logic                cond;
    logic                taken;

    // operands captured alongside the decode register
    always_ff @(posedge clk) begin
        rs1_q <= rd1;
        rs2_q <= rd2;
    end

    // ========================================
    // alu
    // ========================================
    assign op_b  = dec_op.use_imm ? dec_op.imm : rs2_q;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_op.alu_op)
            rv32_isa_pkg::ALU_SUB:  alu = rs1_q - op_b;
            rv32_isa_pkg::ALU_AND:  alu = rs1_q & op_b;
            rv32_isa_pkg::ALU_OR:   alu = rs1_q | op_b;
            rv32_isa_pkg::ALU_XOR:  alu = rs1_q ^ op_b;
            rv32_isa_pkg::ALU_SLL:  alu = rs1_q << shamt;
            rv32_isa_pkg::ALU_SRL:  alu = rs1_q >> shamt;
            rv32_isa_pkg::ALU_SRA:  alu = rv32_isa_pkg::data_t'($signed(rs1_q) >>> shamt);
            rv32_isa_pkg::ALU_SLT:  alu = rv32_isa_pkg::data_t'($signed(rs1_q) < $signed(op_b));
            rv32_isa_pkg::ALU_SLTU: alu = rv32_isa_pkg::data_t'(rs1_q < op_b);
            default:                alu = rs1_q + op_b;
        endcase
    end

    // branch compare, always register against register
    always_comb begin
        case (dec_op.br_kind)
            rv32_isa_pkg::BR_NE:  cond = rs1_q != rs2_q;
            rv32_isa_pkg::BR_LT:  cond = $signed(rs1_q) < $signed(rs2_q);
            rv32_isa_pkg::BR_GE:  cond = $signed(rs1_q) >= $signed(rs2_q);
            rv32_isa_pkg::BR_LTU: cond = rs1_q < rs2_q;
            rv32_isa_pkg::BR_GEU: cond = rs1_q >= rs2_q;
            default:              cond = rs1_q == rs2_q;
        endcase
    end

    assign taken = dec_op.is_branch && cond;

    // ========================================
    // result register
    // ========================================
    always_ff @(posedge clk) begin
        ex_res.hart     <= dec_op.hart;
        ex_res.pc       <= dec_op.pc;
        ex_res.rd       <= dec_op.rd;
        ex_res.rd_wen   <= dec_op.rd_wen;
        // link value for jal, upper immediate for lui
        ex_res.result   <= dec_op.is_jal ? dec_op.pc + 32'd4 :
                           dec_op.is_lui ? dec_op.imm : alu;
        ex_res.redirect <= dec_op.is_jal || taken;
        ex_res.target   <= dec_op.pc + dec_op.imm;
        if (!pito_io_rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

endmodule

// File: hw/pito_fetch.sv
`timescale 1ns/1ps

module pito_fetch #(
    parameter int NUM_HARTS   = 8,
    parameter int IMEM_ADDR_W = 13
) (
    input  logic                     clk,
    input  logic                     pito_io_rst_n,
    input  logic                     pito_io_program,
    input  pito_core_pkg::imem_wr_t  imem_wr,
    input  logic                     pc_upd_en,
    input  pito_core_pkg::hart_id_t  pc_upd_hart,
    input  pito_core_pkg::pc_t       pc_upd_val,
    output logic                     fet_valid,
    output pito_core_pkg::hart_id_t  fet_hart,
    output pito_core_pkg::pc_t       fet_pc,
    output rv32_isa_pkg::instr_u     fet_instr
);

    localparam int HW = $clog2(NUM_HARTS);

    // power of two hart count, so the counter wraps by itself
    logic [HW-1:0]      hart_cnt;
    pito_core_pkg::pc_t pc_q [NUM_HARTS];
    rv32_isa_pkg::data_t imem [2**IMEM_ADDR_W];

    // ========================================
    // round robin hart counter
    // ========================================
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            hart_cnt <= '0;
        end else begin
            hart_cnt <= hart_cnt + 1'b1;
        end
    end

    // per hart pc, parked at start address while programming
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n || pito_io_program) begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                pc_q[h] <= pito_core_pkg::pc_t'(h) << pito_core_pkg::HART_BASE_SHIFT;
            end
        end else if (pc_upd_en) begin
            pc_q[pc_upd_hart[HW-1:0]] <= pc_upd_val;
        end
    end

    // ========================================
    // instruction memory
    // ========================================
    // io write port, any time
    always_ff @(posedge clk) begin
        if (imem_wr.en) begin
            imem[imem_wr.addr[IMEM_ADDR_W-1:0]] <= imem_wr.data;
        end
    end

    // synchronous read, record valid one cycle after selection
    always_ff @(posedge clk) begin
        fet_instr <= imem[pc_q[hart_cnt][IMEM_ADDR_W+1:2]];
        fet_hart  <= pito_core_pkg::hart_id_t'(hart_cnt);
        fet_pc    <= pc_q[hart_cnt];
        if (!pito_io_rst_n) begin
            fet_valid <= 1'b0;
        end else begin
            fet_valid <= !pito_io_program;
        end
    end

    // legal barrel depth, covers the 4 cycle pc loop
    a_num_harts: assert property (@(posedge clk)
        NUM_HARTS >= 4 && NUM_HARTS <= 8 && (NUM_HARTS & (NUM_HARTS - 1)) == 0);

endmodule

// File: hw/pito_regfile.sv
`timescale 1ns/1ps

module pito_regfile #(
    parameter int NUM_HARTS = 8
) (
    input  logic                    clk,
    input  pito_core_pkg::hart_id_t rd_hart,
    input  rv32_isa_pkg::reg_addr_t ra1,
    input  rv32_isa_pkg::reg_addr_t ra2,
    output rv32_isa_pkg::data_t     rd1,
    output rv32_isa_pkg::data_t     rd2,
    input  logic                    wen,
    input  pito_core_pkg::hart_id_t w_hart,
    input  rv32_isa_pkg::reg_addr_t wa,
    input  rv32_isa_pkg::data_t     wd
);

    localparam int HW = $clog2(NUM_HARTS);

    // one bank of 32 per hart
    rv32_isa_pkg::data_t bank [NUM_HARTS][32];

    // two async read ports, x0 hardwired
    assign rd1 = (ra1 == 5'd0) ? '0 : bank[rd_hart[HW-1:0]][ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : bank[rd_hart[HW-1:0]][ra2];

    // single write port from the write stage
    always_ff @(posedge clk) begin
        if (wen) begin
            bank[w_hart[HW-1:0]][wa] <= wd;
        end
    end

endmodule

// File: hw/pito_writeback.sv
`timescale 1ns/1ps

module pito_writeback (
    input  logic                    clk,
    input  logic                    pito_io_rst_n,
    input  logic                    ex_valid,
    input  pito_core_pkg::ex_res_t  ex_res,
    output logic                    wen,
    output pito_core_pkg::hart_id_t w_hart,
    output rv32_isa_pkg::reg_addr_t wa,
    output rv32_isa_pkg::data_t     wd,
    output logic                    pc_upd_en,
    output pito_core_pkg::hart_id_t pc_upd_hart,
    output pito_core_pkg::pc_t      pc_upd_val,
    output pito_core_pkg::retire_t  retire
);

    // ========================================
    // register write
    // ========================================
    assign wen    = ex_valid && ex_res.rd_wen;
    assign w_hart = ex_res.hart;
    assign wa     = ex_res.rd;
    assign wd     = ex_res.result;

    // next pc back to fetch, every valid slot
    assign pc_upd_en   = ex_valid;
    assign pc_upd_hart = ex_res.hart;
    assign pc_upd_val  = ex_res.redirect ? ex_res.target : ex_res.pc + 32'd4;

    // ========================================
    // retire record
    // ========================================
    always_ff @(posedge clk) begin
        retire.hart    <= ex_res.hart;
        retire.pc      <= ex_res.pc;
        retire.rd_wen  <= ex_res.rd_wen;
        retire.rd      <= ex_res.rd;
        retire.rd_data <= ex_res.result;
        if (!pito_io_rst_n) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= ex_valid;
        end
    end

    // redirect targets must land on a word boundary
    a_target_aligned: assert property (@(posedge clk) disable iff (!pito_io_rst_n)
        ex_valid && ex_res.redirect |-> ex_res.target[1:0] == 2'b00);

endmodule

// File: hw/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // ========================================
    // base widths
    // ========================================
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ========================================
    // instruction word, two field layouts
    // ========================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_kind_t;

endpackage

// File: project.f
hw/rv32_isa_pkg.sv
hw/pito_core_pkg.sv
hw/pito_fetch.sv
hw/pito_decode.sv
hw/pito_regfile.sv
hw/pito_execute.sv
hw/pito_writeback.sv
hw/pito_core.sv
verif/pito_core_tb.sv

// File: verif/pito_core_tb.sv
`timescale 1ns/1ps

module pito_core_tb;

    // ========================================
    // dut signals
    // ========================================
    logic                    clk;
    logic                    pito_io_rst_n;
    logic                    pito_io_program;
    pito_core_pkg::imem_wr_t imem_wr;
    pito_core_pkg::retire_t  retire;

    // program words and expected retires, one queue per hart
    logic [31:0]             prog_addr [$];
    logic [31:0]             prog_data [$];
    pito_core_pkg::retire_t  exp_q [8][$];

    int                      cycles;
    int                      limit;
    int                      rel;
    int                      drop_cycle;
    int                      pending;
    pito_core_pkg::hart_id_t next_hart;

    pito_core #(.NUM_HARTS(8), .IMEM_ADDR_W(13)) UUT (
        .clk(clk), .pito_io_rst_n(pito_io_rst_n), .pito_io_program(pito_io_program),
        .imem_wr(imem_wr), .retire(retire)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // helpers
    // ========================================
    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    // one cycle, inputs change 5 ns after the edge
    task automatic step();
        @(posedge clk);
        #5;
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: retires did not complete within %0d cycles", limit);
            stop_run();
        end
    endtask

    task automatic check_pc(input string name, input pito_core_pkg::pc_t got,
                            input pito_core_pkg::pc_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input rv32_isa_pkg::data_t got,
                              input rv32_isa_pkg::data_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input rv32_isa_pkg::reg_addr_t got,
                             input rv32_isa_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_hart(input string name, input pito_core_pkg::hart_id_t got,
                              input pito_core_pkg::hart_id_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s: got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    // ========================================
    // vectors file
    // ========================================
    task automatic load_vectors();
        int                     fd;
        int                     n;
        int                     maxq;
        logic [8*8-1:0]         tag;
        logic [8*160-1:0]       line;
        logic [31:0]            f [5];
        pito_core_pkg::retire_t e;
        fd = $fopen("verif/pito_core_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vectors file verif/pito_core_vectors.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            tag = '0;
            n = $fscanf(fd, "%s", tag);
            if (n == 1) begin
                if (tag == "#") begin
                    n = $fgets(line, fd);
                end else if (tag == "P") begin
                    n = $fscanf(fd, "%h %h", f[0], f[1]);
                    prog_addr.push_back(f[0]);
                    prog_data.push_back(f[1]);
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                    e         = '0;
                    e.valid   = 1'b1;
                    e.hart    = f[0][2:0];
                    e.pc      = f[1];
                    e.rd_wen  = f[2][0];
                    e.rd      = f[3][4:0];
                    e.rd_data = f[4];
                    exp_q[f[0][2:0]].push_back(e);
                end else begin
                    $display("unknown line tag in the vectors file");
                    stop_run();
                end
            end
        end
        $fclose(fd);
        maxq    = 0;
        pending = 0;
        for (int h = 0; h < 8; h++) begin
            pending += exp_q[h].size();
            if (exp_q[h].size() > maxq) begin
                maxq = exp_q[h].size();
            end
        end
        limit = prog_addr.size() + 8 * maxq + 100;
    endtask

    // ========================================
    // retire checking
    // ========================================
    task automatic check_retire();
        pito_core_pkg::retire_t e;
        if (exp_q[retire.hart].size() == 0) begin
            $display("hart %0d retired at pc %h after its expected records ran out",
                     retire.hart, retire.pc);
            stop_run();
        end else begin
            e = exp_q[retire.hart].pop_front();
            // strict round robin order
            check_hart("retire.hart", retire.hart, next_hart);
            check_pc("retire.pc", retire.pc, e.pc);
            check_data("retire.rd_wen", {31'b0, retire.rd_wen}, {31'b0, e.rd_wen});
            // rd and data only mean something on a write
            if (e.rd_wen) begin
                check_reg("retire.rd", retire.rd, e.rd);
                check_data("retire.rd_data", retire.rd_data, e.rd_data);
            end
            next_hart = next_hart + 1'b1;
            pending--;
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        pito_io_rst_n   = 1'b0;
        pito_io_program = 1'b1;
        imem_wr         = '0;
        cycles          = 0;
        limit           = 1000;
        next_hart       = '0;
        load_vectors();

        repeat (10) step();
        pito_io_rst_n = 1'b1;
        rel           = cycles;

        // program load through the io port
        for (int i = 0; i < prog_addr.size(); i++) begin
            imem_wr.en   = 1'b1;
            imem_wr.addr = prog_addr[i][12:0];
            imem_wr.data = prog_data[i];
            step();
        end
        imem_wr.en = 1'b0;

        // release so the first valid fetch lands on hart 0
        while ((cycles - rel) % 8 != 0) begin
            step();
        end
        pito_io_program = 1'b0;
        drop_cycle      = cycles;

        while (pending > 0) begin
            step();
            // four cycle latency, then one retire every cycle
            check_data("retire.valid", {31'b0, retire.valid},
                       {31'b0, (cycles - drop_cycle) >= 4});
            if (retire.valid) begin
                check_retire();
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: verif/pito_core_vectors.txt
# P word_addr instr : instruction word written at a word address
# E hart pc rd_wen rd rd_data : expected retire, rd and rd_data only checked when rd_wen is 1
P 0000 ff000093
P 0001 4020d113
P 0002 01c0d193
P 0003 00319233
P 0400 0f000093
P 0401 00f0e113
P 0402 001141b3
P 0403 00117233
P 0800 123452b7
P 0801 00128013
P 0802 00028333
P 0803 405303b3
P 0c00 fff00093
P 0c01 0000a133
P 0c02 0000b1b3
P 0c03 00213213
P 1000 00300093
P 1001 00008463
P 1002 00009463
P 1004 00108113
P 1400 00c000ef
P 1403 ffc08113
P 1404 0020e463
P 1405 fff14193
P 1800 ffe00093
P 1801 0000c863
P 1805 fe00fce3
P 1803 4010d133
P 1c00 03c00093
P 1c01 800fa06f
E 0 00000000 1 01 fffffff0
E 1 00001000 1 01 000000f0
E 2 00002000 1 05 12345000
E 3 00003000 1 01 ffffffff
E 4 00004000 1 01 00000003
E 5 00005000 1 01 00005004
E 6 00006000 1 01 fffffffe
E 7 00007000 1 01 0000003c
E 0 00000004 1 02 fffffffc
E 1 00001004 1 02 000000ff
E 2 00002004 0 00 00000000
E 3 00003004 1 02 00000001
E 4 00004004 0 00 00000000
E 5 0000500c 1 02 00005000
E 6 00006004 0 00 00000000
E 7 00007004 0 00 00000000
E 0 00000008 1 03 0000000f
E 1 00001008 1 03 0000000f
E 2 00002008 1 06 12345000
E 3 00003008 1 03 00000000
E 4 00004008 0 00 00000000
E 5 00005010 0 00 00000000
E 6 00006014 0 00 00000000
E 7 00001004 1 02 0000003f
E 0 0000000c 1 04 00078000
E 1 0000100c 1 04 000000f0
E 2 0000200c 1 07 00000000
E 3 0000300c 1 04 00000001
E 4 00004010 1 02 00000004
E 5 00005014 1 03 ffffafff
E 6 0000600c 1 02 ffffffff
E 7 00001008 1 03 00000003
